//--- hw/feLoadPkg.sv
// Load-file widths, record and diagnostic codes, state enums and the KL10 reset step table
package feLoadPkg;

  // Widths with a meaning
  typedef logic [6:0]  tChar;
  typedef logic [15:0] tWord16;
  typedef logic [10:0] tCramAddr;
  typedef logic [85:0] tCramWord;    // 80 bits plus CALL/DISP
  typedef logic [8:0]  tDramAddr;
  typedef logic [6:0]  tDiagFunc;
  typedef logic [35:0] tEbusWord;

  // Separators in the load file
  localparam tChar DELIM_COMMA = 7'h2C;
  localparam tChar LINE_END    = 7'h0A;
  localparam tChar IGNORED_CR  = 7'h0D;

  // Record types
  localparam tChar REC_CRAM    = 7'h43;  // C
  localparam tChar REC_DRAM    = 7'h44;  // D
  localparam tChar REC_ZERO    = 7'h5A;  // Z
  localparam tChar REC_COMMENT = 7'h3B;  // ;

  localparam int CRAM_GROUP_WORDS = 6;
  localparam int DRAM_GROUP_WORDS = 3;

  // Diagnostic functions, KL10 octal codes
  localparam tDiagFunc diagStopClock       = 7'o000;
  localparam tDiagFunc diagStartClock      = 7'o001;
  localparam tDiagFunc diagStepClock       = 7'o002;
  localparam tDiagFunc diagCondStep        = 7'o004;
  localparam tDiagFunc diagSetReset        = 7'o006;
  localparam tDiagFunc diagClrReset        = 7'o007;
  localparam tDiagFunc diagClrRun          = 7'o010;
  localparam tDiagFunc diagSetRun          = 7'o011;
  localparam tDiagFunc diagContinue        = 7'o012;
  localparam tDiagFunc diagBurstCtrRh      = 7'o042;
  localparam tDiagFunc diagBurstCtrLh      = 7'o043;
  localparam tDiagFunc diagClkSrcRate      = 7'o044;
  localparam tDiagFunc diagEboxClkDisables = 7'o045;
  localparam tDiagFunc diagResetParRegs    = 7'o046;
  localparam tDiagFunc diagMboxDisParChk   = 7'o047;
  localparam tDiagFunc diagEnableKl        = 7'o067;
  localparam tDiagFunc diagInitChannels    = 7'o070;
  localparam tDiagFunc diagWriteMbox       = 7'o071;
  localparam tDiagFunc diagEbusLoad        = 7'o076;

  // EBUS cycle and sequencer timing, in clocks
  localparam int FUNC_STROBE_CYCLES  = 17;
  localparam int WRITE_STROBE_CYCLES = 2;
  localparam int WRITE_DRIVE_CYCLES  = 3;
  localparam int CROBAR_DELAY        = 10;
  localparam int SYNC_WAIT           = 5;
  localparam int SYNC_TRIES          = 5;

  typedef enum logic [1:0] {stepFunc, stepWrite, stepSync} tStepKind;

  typedef enum logic [2:0] {
    parseWc, parseAdr, parseData, parseCksum, parseSkip
  } tParseState;

  typedef enum logic [2:0] {
    seqHold, seqDelay, seqIssue, seqWait, seqSyncWait1, seqSyncWait2, seqSyncClk, seqFinish
  } tSeqState;

  typedef struct packed {
    tStepKind kind;
    tDiagFunc func;
    tEbusWord data;
  } tResetStep;

  localparam int RESET_STEP_COUNT = 26;

  // Master reset, soft reset and start, in issue order
  localparam tResetStep RESET_STEPS [RESET_STEP_COUNT] = '{
    '{stepFunc,  diagClrRun,          36'o0},
    // Master reset phase 1
    '{stepWrite, diagClkSrcRate,      36'o0},
    '{stepFunc,  diagStopClock,       36'o0},
    '{stepFunc,  diagSetReset,        36'o0},
    '{stepWrite, diagResetParRegs,    36'o0},
    '{stepWrite, diagMboxDisParChk,   36'o0},
    '{stepWrite, diagBurstCtrRh,      36'o0},
    '{stepWrite, diagBurstCtrLh,      36'o0},
    '{stepWrite, diagEboxClkDisables, 36'o0},
    '{stepFunc,  diagStartClock,      36'o0},
    '{stepWrite, diagInitChannels,    36'o0},
    '{stepWrite, diagBurstCtrRh,      36'o0},
    // MBOX sync loop, func is the clock step it issues
    '{stepSync,  diagStepClock,       36'o0},
    // Master reset phase 2
    '{stepFunc,  diagCondStep,        36'o0},
    '{stepFunc,  diagClrReset,        36'o0},
    '{stepWrite, diagEnableKl,        36'o0},
    '{stepWrite, diagEbusLoad,        36'o0},
    '{stepWrite, diagWriteMbox,       36'o120},
    // Soft reset
    '{stepFunc,  diagSetReset,        36'o0},
    '{stepFunc,  diagStartClock,      36'o0},
    '{stepFunc,  diagStopClock,       36'o0},
    '{stepFunc,  diagCondStep,        36'o0},
    '{stepFunc,  diagClrReset,        36'o0},
    // Start the machine
    '{stepFunc,  diagStartClock,      36'o0},
    '{stepFunc,  diagSetRun,          36'o0},
    '{stepFunc,  diagContinue,        36'o0}
  };

endpackage

//--- hw/asciiWordDecoder.sv
// Load-file character stream to 16-bit field words with first and last field flags
`timescale 1ns/100ps

module asciiWordDecoder import feLoadPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   charValid,
  input  tChar   charData,
  output logic   wordValid,
  output tWord16 wordData,
  output logic   firstField,
  output logic   lastField,
  output tChar   recType
);

  // Position inside the current line
  typedef enum logic [1:0] {posType, posSpace, posField} tLinePos;

  tLinePos linePos;
  tWord16  acc;
  logic    atFirst;
  logic    takeChar;
  logic    isComma;
  logic    isLineEnd;
  logic    closeField;

  // Carriage returns never reach the line logic
  assign takeChar  = charValid && (charData != IGNORED_CR);
  assign isComma   = takeChar && (charData == DELIM_COMMA);
  assign isLineEnd = takeChar && (charData == LINE_END);

  // Comma or line end closes a field
  // A bare type line still yields one empty field
  assign closeField = ((linePos == posField) && (isComma || isLineEnd)) ||
                      ((linePos == posSpace) && isLineEnd);

  ////////////////////////////////
  // Line position and flags
  ////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      linePos    <= posType;
      recType    <= '0;
      atFirst    <= 1'b0;
      wordValid  <= 1'b0;
      firstField <= 1'b0;
      lastField  <= 1'b0;
    end else begin
      wordValid <= closeField;
      if (closeField) begin
        firstField <= atFirst;
        lastField  <= isLineEnd;
        atFirst    <= 1'b0;
      end
      if (takeChar) begin
        case (linePos)
          posType: begin
            // Blank lines are skipped
            if (!isLineEnd) begin
              recType <= charData;
              atFirst <= 1'b1;
              linePos <= posSpace;
            end
          end
          posSpace: linePos <= isLineEnd ? posType : posField;
          default: begin
            if (isLineEnd) linePos <= posType;
          end
        endcase
      end
    end
  end

  ////////////////////////////////
  // Field accumulator
  ////////////////////////////////
  always_ff @(posedge clk) begin
    if (closeField) wordData <= (linePos == posField) ? acc : '0;
    if ((linePos == posSpace) || closeField) begin
      acc <= '0;
    end else if ((linePos == posField) && takeChar) begin
      // First character is the most significant, 6 bits each
      acc <= {acc[9:0], charData[5:0]};
    end
  end

endmodule

//--- hw/loadRecordParser.sv
// C and D record parser with CRAM and DRAM word assembly, address tracking and checksum check
`timescale 1ns/100ps

module loadRecordParser import feLoadPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     wordValid,
  input  tWord16   wordData,
  input  logic     firstField,
  input  logic     lastField,
  input  tChar     recType,
  output logic     cramWe,
  output tCramAddr cramAddr,
  output tCramWord cramData,
  output logic     dramWe,
  output tDramAddr dramAddr,
  output tWord16   dramEven,
  output tWord16   dramOdd,
  output tWord16   dramCommon,
  output logic     loadDone,
  output logic     checksumError,
  output logic     formatError
);

  tParseState state;
  tWord16     wcLeft;
  tWord16     sum;
  tWord16     sumNext;
  logic       lineCram;   // current data line is C, else D
  logic       lineEnd;    // WC of zero marks an end record
  logic [2:0] groupCnt;
  logic       groupLast;
  logic       isDataType;
  logic       isSkipType;

  assign isDataType = (recType == REC_CRAM) || (recType == REC_DRAM);
  assign isSkipType = (recType == REC_ZERO) || (recType == REC_COMMENT);
  assign sumNext    = sum + wordData;

  // Six words per CRAM word, three per DRAM pair
  assign groupLast = lineCram ? (groupCnt == 3'(CRAM_GROUP_WORDS - 1)) :
                                (groupCnt == 3'(DRAM_GROUP_WORDS - 1));

  ////////////////////////////////
  // Record FSM
  ////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state         <= parseWc;
      wcLeft        <= '0;
      sum           <= '0;
      lineCram      <= 1'b0;
      lineEnd       <= 1'b0;
      groupCnt      <= '0;
      cramWe        <= 1'b0;
      dramWe        <= 1'b0;
      cramAddr      <= '0;
      dramAddr      <= '0;
      loadDone      <= 1'b0;
      checksumError <= 1'b0;
      formatError   <= 1'b0;
    end else begin
      cramWe <= 1'b0;
      dramWe <= 1'b0;
      // Step to the next location right after each write
      if (cramWe) cramAddr <= cramAddr + 1'b1;
      if (dramWe) dramAddr <= dramAddr + 2'd2;
      if (wordValid) begin
        case (state)
          parseWc: begin
            wcLeft   <= wordData;
            sum      <= wordData;
            lineCram <= (recType == REC_CRAM);
            lineEnd  <= (wordData == '0);
            groupCnt <= '0;
            // Unknown type, or a data line that stops after WC
            if (!firstField || !(isDataType || isSkipType) || (isDataType && lastField)) begin
              formatError <= 1'b1;
            end
            if (lastField) state <= parseWc;
            else if (isDataType && firstField) state <= parseAdr;
            else state <= parseSkip;
          end
          parseAdr: begin
            sum <= sumNext;
            // ADR 0 resumes where this type's last line stopped
            if (wordData != '0) begin
              if (lineCram) cramAddr <= wordData[10:0];
              else dramAddr <= {wordData[8:1], 1'b0};
            end
            if (lastField) begin
              formatError <= 1'b1;
              state       <= parseWc;
            end else begin
              state <= lineEnd ? parseCksum : parseData;
            end
          end
          parseData: begin
            sum      <= sumNext;
            wcLeft   <= wcLeft - 1'b1;
            groupCnt <= groupLast ? 3'd0 : groupCnt + 1'b1;
            if (groupLast) begin
              cramWe <= lineCram;
              dramWe <= !lineCram;
            end
            if (lastField) begin
              formatError <= 1'b1;
              state       <= parseWc;
            end else if (wcLeft == 16'd1) begin
              state <= parseCksum;
            end
          end
          parseCksum: begin
            // Negated checksum brings the line total to zero
            if (sumNext != '0) checksumError <= 1'b1;
            if (lastField) begin
              state <= parseWc;
              if (lineEnd && !lineCram) loadDone <= 1'b1;
            end else begin
              formatError <= 1'b1;
              state       <= parseSkip;
            end
          end
          default: begin
            if (lastField) state <= parseWc;
          end
        endcase
      end
    end
  end

  ////////////////////////////////
  // Word assembly
  ////////////////////////////////
  always_ff @(posedge clk) begin
    if (wordValid && (state == parseData)) begin
      if (lineCram) begin
        case (groupCnt)
          3'd0: cramData[79:64] <= wordData;
          3'd1: cramData[63:48] <= wordData;
          3'd2: cramData[47:32] <= wordData;
          3'd3: cramData[31:16] <= wordData;
          3'd4: cramData[15:0]  <= wordData;
          default: cramData[85:80] <= wordData[5:0];  // CALL and DISP
        endcase
      end else begin
        case (groupCnt)
          3'd0: dramEven <= wordData;
          3'd1: dramOdd  <= wordData;
          default: dramCommon <= wordData;
        endcase
      end
    end
  end

endmodule

//--- hw/diagCycleGen.sv
// One EBUS diagnostic function or write cycle with fixed strobe and drive timing
`timescale 1ns/100ps

module diagCycleGen import feLoadPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     cycStart,
  input  logic     cycWrite,
  input  tDiagFunc cycFunc,
  input  tEbusWord cycData,
  output tDiagFunc diagFunc,
  output logic     diagStrobe,
  output tEbusWord ebusData,
  output logic     ebusDriving,
  output logic     cycDone
);

  logic     busy;
  logic     isWrite;
  logic [$clog2(FUNC_STROBE_CYCLES + 2)-1:0] cnt;
  tEbusWord dataReg;

  // Count runs down to zero
  // Longest output ends at 2, one quiet cycle, then done at 0
  assign diagStrobe = busy &&
                      (isWrite ? (cnt >= WRITE_DRIVE_CYCLES - WRITE_STROBE_CYCLES + 2) :
                                 (cnt >= 2));
  assign ebusDriving = busy && isWrite && (cnt >= 2);
  assign cycDone     = busy && (cnt == '0);

  // Bus floats to zero when not driven
  assign ebusData = ebusDriving ? dataReg : '0;

  ////////////////////////////////
  // Cycle timing
  ////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      busy    <= 1'b0;
      isWrite <= 1'b0;
      cnt     <= '0;
    end else if (!busy) begin
      if (cycStart) begin
        busy    <= 1'b1;
        isWrite <= cycWrite;
        // First active cycle holds longest length plus one
        cnt     <= cycWrite ? $bits(cnt)'(WRITE_DRIVE_CYCLES + 1) :
                              $bits(cnt)'(FUNC_STROBE_CYCLES + 1);
      end
    end else begin
      cnt <= cnt - 1'b1;
      if (cnt == '0) busy <= 1'b0;
    end
  end

  // Function code and data latched for the whole cycle
  always_ff @(posedge clk) begin
    if (!busy && cycStart) begin
      diagFunc <= cycFunc;
      dataReg  <= cycData;
    end
  end

endmodule

//--- hw/klResetSequencer.sv
// Crobar hold and KL10 reset step sequencer with the MBOX sync loop
`timescale 1ns/100ps

module klResetSequencer import feLoadPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     loadDone,
  input  logic     checksumError,
  input  logic     formatError,
  input  logic     aChangeComingN,
  input  logic     cycDone,
  output logic     crobar,
  output logic     cycStart,
  output logic     cycWrite,
  output tDiagFunc cycFunc,
  output tEbusWord cycData,
  output logic     syncError,
  output logic     seqDone
);

  tSeqState state;
  tStepKind stepKind;
  logic [$clog2(RESET_STEP_COUNT)-1:0] stepIdx;
  logic [$clog2(CROBAR_DELAY)-1:0]     delayCnt;
  logic [$clog2(SYNC_WAIT)-1:0]        waitCnt;
  logic [$clog2(SYNC_TRIES)-1:0]       tryCnt;
  logic lastStep;
  logic stepDone;

  // Current table entry drives the cycle request
  // Sync entry carries the step-clock function
  assign stepKind = RESET_STEPS[stepIdx].kind;
  assign cycFunc  = RESET_STEPS[stepIdx].func;
  assign cycData  = RESET_STEPS[stepIdx].data;
  assign cycWrite = (stepKind == stepWrite);
  assign lastStep = (stepIdx == $bits(stepIdx)'(RESET_STEP_COUNT - 1));

  assign cycStart = ((state == seqIssue) && (stepKind != stepSync)) ||
                    ((state == seqSyncWait2) && (waitCnt == '0));

  // Step ends on its cycle, on a clear sync check, or when tries run out
  assign stepDone = ((state == seqWait) && cycDone) ||
                    ((state == seqSyncWait1) && (waitCnt == '0) && aChangeComingN) ||
                    ((state == seqSyncClk) && cycDone &&
                     (tryCnt == $bits(tryCnt)'(SYNC_TRIES - 1)));

  ////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state     <= seqHold;
      crobar    <= 1'b1;
      stepIdx   <= '0;
      delayCnt  <= '0;
      waitCnt   <= '0;
      tryCnt    <= '0;
      syncError <= 1'b0;
      seqDone   <= 1'b0;
    end else begin
      case (state)
        seqHold: begin
          // Release only after a clean load
          if (loadDone && !checksumError && !formatError) begin
            crobar   <= 1'b0;
            delayCnt <= $bits(delayCnt)'(CROBAR_DELAY - 1);
            state    <= seqDelay;
          end
        end
        seqDelay: begin
          if (delayCnt == '0) state <= seqIssue;
          else delayCnt <= delayCnt - 1'b1;
        end
        seqIssue: begin
          if (stepKind == stepSync) begin
            waitCnt <= $bits(waitCnt)'(SYNC_WAIT - 1);
            tryCnt  <= '0;
            state   <= seqSyncWait1;
          end else begin
            state <= seqWait;
          end
        end
        seqSyncWait1: begin
          // A CHANGE COMING still low, wait again then step the clock
          if (waitCnt != '0) begin
            waitCnt <= waitCnt - 1'b1;
          end else if (!aChangeComingN) begin
            waitCnt <= $bits(waitCnt)'(SYNC_WAIT - 1);
            state   <= seqSyncWait2;
          end
        end
        seqSyncWait2: begin
          if (waitCnt == '0) state <= seqSyncClk;
          else waitCnt <= waitCnt - 1'b1;
        end
        seqSyncClk: begin
          if (cycDone) begin
            if (tryCnt == $bits(tryCnt)'(SYNC_TRIES - 1)) begin
              if (!aChangeComingN) syncError <= 1'b1;
            end else begin
              tryCnt  <= tryCnt + 1'b1;
              waitCnt <= $bits(waitCnt)'(SYNC_WAIT - 1);
              state   <= seqSyncWait1;
            end
          end
        end
        default: ;  // seqWait and seqFinish wait on stepDone
      endcase

      // Advance through the table
      if (stepDone) begin
        if (lastStep) begin
          state   <= seqFinish;
          seqDone <= 1'b1;
        end else begin
          stepIdx <= stepIdx + 1'b1;
          state   <= seqIssue;
        end
      end
    end
  end

endmodule

//--- hw/frontEnd.sv
// Front-end top with load-file decoder, record parser, reset sequencer and EBUS cycle generator
`timescale 1ns/100ps

module frontEnd import feLoadPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     charValid,
  input  tChar     charData,
  input  logic     aChangeComingN,
  output logic     cramWe,
  output tCramAddr cramAddr,
  output tCramWord cramData,
  output logic     dramWe,
  output tDramAddr dramAddr,
  output tWord16   dramEven,
  output tWord16   dramOdd,
  output tWord16   dramCommon,
  output logic     loadDone,
  output logic     checksumError,
  output logic     formatError,
  output logic     crobar,
  output tDiagFunc diagFunc,
  output logic     diagStrobe,
  output tEbusWord ebusData,
  output logic     ebusDriving,
  output logic     syncError,
  output logic     seqDone
);

  // Decoder to parser
  logic     wordValid;
  tWord16   wordData;
  logic     firstField;
  logic     lastField;
  tChar     recType;

  // Sequencer to cycle generator
  logic     cycStart;
  logic     cycWrite;
  tDiagFunc cycFunc;
  tEbusWord cycData;
  logic     cycDone;

  asciiWordDecoder i_decoder (
    .clk        (clk),
    .rstN       (rstN),
    .charValid  (charValid),
    .charData   (charData),
    .wordValid  (wordValid),
    .wordData   (wordData),
    .firstField (firstField),
    .lastField  (lastField),
    .recType    (recType)
  );

  loadRecordParser i_parser (
    .clk           (clk),
    .rstN          (rstN),
    .wordValid     (wordValid),
    .wordData      (wordData),
    .firstField    (firstField),
    .lastField     (lastField),
    .recType       (recType),
    .cramWe        (cramWe),
    .cramAddr      (cramAddr),
    .cramData      (cramData),
    .dramWe        (dramWe),
    .dramAddr      (dramAddr),
    .dramEven      (dramEven),
    .dramOdd       (dramOdd),
    .dramCommon    (dramCommon),
    .loadDone      (loadDone),
    .checksumError (checksumError),
    .formatError   (formatError)
  );

  klResetSequencer i_sequencer (
    .clk            (clk),
    .rstN           (rstN),
    .loadDone       (loadDone),
    .checksumError  (checksumError),
    .formatError    (formatError),
    .aChangeComingN (aChangeComingN),
    .cycDone        (cycDone),
    .crobar         (crobar),
    .cycStart       (cycStart),
    .cycWrite       (cycWrite),
    .cycFunc        (cycFunc),
    .cycData        (cycData),
    .syncError      (syncError),
    .seqDone        (seqDone)
  );

  diagCycleGen i_cycleGen (
    .clk         (clk),
    .rstN        (rstN),
    .cycStart    (cycStart),
    .cycWrite    (cycWrite),
    .cycFunc     (cycFunc),
    .cycData     (cycData),
    .diagFunc    (diagFunc),
    .diagStrobe  (diagStrobe),
    .ebusData    (ebusData),
    .ebusDriving (ebusDriving),
    .cycDone     (cycDone)
  );

endmodule

//--- verif/frontEndAsserts.sv
// Bound EBUS cycle, drive and write enable assertions for the front-end top
`timescale 1ns/100ps

module frontEndAsserts import feLoadPkg::*; (
  input logic     clk,
  input logic     rstN,
  input logic     diagStrobe,
  input logic     ebusDriving,
  input tEbusWord ebusData,
  input logic     cramWe,
  input logic     dramWe
);

  // Failure count, watched by the testbench
  int errCount = 0;

  ////////////////////////////////
  // Strobe and drive lengths
  ////////////////////////////////
  // Function cycle strobe
  funcStrobeLen: assert property (@(posedge clk) disable iff (!rstN)
    $rose(diagStrobe) && !ebusDriving |-> diagStrobe[*FUNC_STROBE_CYCLES] ##1 !diagStrobe)
    else begin
      errCount++;
      $error("function strobe length wrong");
    end

  // Write cycle strobe
  writeStrobeLen: assert property (@(posedge clk) disable iff (!rstN)
    $rose(diagStrobe) && ebusDriving |-> diagStrobe[*WRITE_STROBE_CYCLES] ##1 !diagStrobe)
    else begin
      errCount++;
      $error("write strobe length wrong");
    end

  // Drive starts with the strobe and lasts three clocks
  driveLen: assert property (@(posedge clk) disable iff (!rstN)
    $rose(ebusDriving) |-> $rose(diagStrobe) ##0
      (ebusDriving[*WRITE_DRIVE_CYCLES] ##1 !ebusDriving))
    else begin
      errCount++;
      $error("EBUS drive length wrong");
    end

  ////////////////////////////////
  // Bus and write enables
  ////////////////////////////////
  idleBusZero: assert property (@(posedge clk) disable iff (!rstN)
    !ebusDriving |-> (ebusData == '0))
    else begin
      errCount++;
      $error("ebusData not zero while idle");
    end

  cramWePulse: assert property (@(posedge clk) disable iff (!rstN) cramWe |=> !cramWe)
    else begin
      errCount++;
      $error("cramWe longer than one cycle");
    end

  dramWePulse: assert property (@(posedge clk) disable iff (!rstN) dramWe |=> !dramWe)
    else begin
      errCount++;
      $error("dramWe longer than one cycle");
    end

endmodule

bind frontEnd frontEndAsserts i_asserts (.*);

//--- verif/frontEndTb.sv
// Front-end testbench with load-file stimulus, A CHANGE COMING model, EBUS checks and watchdog
`timescale 1ns/100ps

module frontEndTb import feLoadPkg::*; ();

  localparam int LOAD_WORDS  = 220;   // rough upper bound of words sent in all runs
  localparam int RESET_MAX   = 26 * 22 + SYNC_TRIES * (2 * SYNC_WAIT + 22) + 40;
  localparam int RUN_CYCLES  = 4 * (LOAD_WORDS * 8 + RESET_MAX + 200);

  logic clk = 1'b0;
  logic rstN;
  logic charValid;
  tChar charData;
  logic aChangeComingN;
  logic cramWe, dramWe, loadDone, checksumError, formatError, crobar;
  logic diagStrobe, ebusDriving, syncError, seqDone;
  tCramAddr cramAddr;
  tCramWord cramData;
  tDramAddr dramAddr;
  tWord16   dramEven, dramOdd, dramCommon;
  tDiagFunc diagFunc;
  tEbusWord ebusData;

  // Expected writes and EBUS cycles
  int       expCramAddr[$];
  tCramWord expCramData[$];
  int       expDramAddr[$];
  tWord16   expDram[$];
  tDiagFunc expFunc[$];
  bit       expWrite[$];
  tEbusWord expData[$];
  int  nextCram, nextDram;
  int  holdTries;
  int  clocksSeen;
  logic prevStrobe;

  frontEnd i_dut (.*);

  always #10 clk = ~clk;

  ////////////////////////////////
  // Failure reporting
  ////////////////////////////////
  task automatic stopRun();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [127:0] exp, input logic [127:0] got);
    assert (exp === got) else begin
      $display("error %s expected %h got %h", name, exp, got);
      stopRun();
    end
  endtask

  task automatic checkTrue(input bit cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      stopRun();
    end
  endtask

  // Bound assertion failures end the run too
  always @(i_dut.i_asserts.errCount) begin
    if (i_dut.i_asserts.errCount != 0) begin
      $display("bound assertion failed");
      stopRun();
    end
  end

  initial begin
    #(RUN_CYCLES * 20);
    $display("watchdog expired, the run did not finish");
    stopRun();
  end

  ////////////////////////////////
  // Write checkers
  ////////////////////////////////
  always @(negedge clk) begin
    if (rstN && cramWe) begin
      checkTrue(expCramAddr.size() > 0, "unexpected CRAM write");
      checkValue("cramAddr", expCramAddr.pop_front(), cramAddr);
      checkValue("cramData", expCramData.pop_front(), cramData);
    end
    if (rstN && dramWe) begin
      checkTrue(expDramAddr.size() > 0, "unexpected DRAM write");
      checkValue("dramAddr", expDramAddr.pop_front(), dramAddr);
      checkValue("dramEven", expDram.pop_front(), dramEven);
      checkValue("dramOdd", expDram.pop_front(), dramOdd);
      checkValue("dramCommon", expDram.pop_front(), dramCommon);
    end
  end

  // EBUS cycle order plus the MBOX model, which lets go after holdTries step clocks
  always @(negedge clk) begin
    if (rstN && diagStrobe && !prevStrobe) begin
      checkTrue(!crobar, "EBUS cycle while crobar is high");
      checkTrue(expFunc.size() > 0, "unexpected EBUS cycle");
      checkValue("diagFunc", expFunc.pop_front(), diagFunc);
      checkValue("ebusDriving", expWrite.pop_front(), ebusDriving);
      checkValue("ebusData", expData.pop_front(), ebusData);
      if (diagFunc == diagStepClock) clocksSeen++;
    end
    prevStrobe <= rstN && diagStrobe;
    if (rstN) aChangeComingN <= (clocksSeen >= holdTries);
  end

  ////////////////////////////////
  // Stimulus
  ////////////////////////////////
  task automatic sendChar(input tChar c);
    @(negedge clk);
    charValid = 1'b1;
    charData  = c;
    if ($urandom % 4 == 0) begin
      @(negedge clk);
      charValid = 1'b0;
    end
  endtask

  task automatic sendLine(input tChar t, input tWord16 words[$]);
    sendChar(t);
    sendChar(7'h20);
    foreach (words[i]) begin
      if (i > 0) sendChar(DELIM_COMMA);
      // Three characters of 6 bits with the most significant first
      sendChar(7'h40 | words[i][15:12]);
      sendChar(7'h40 | words[i][11:6]);
      sendChar(7'h40 | words[i][5:0]);
    end
    if ($urandom % 2) sendChar(IGNORED_CR);
    sendChar(LINE_END);
    @(negedge clk);
    charValid = 1'b0;
  endtask

  // One C or D data line with its expected writes queued as it is built
  task automatic sendDataLine(input bit isCram, input int adr, input int groups,
                              input bit corrupt);
    tWord16 words[$];
    tWord16 g[6];
    tWord16 sum;
    int n;
    n = isCram ? CRAM_GROUP_WORDS : DRAM_GROUP_WORDS;
    words.push_back(tWord16'(groups * n));
    words.push_back(tWord16'(adr));
    if (adr != 0) begin
      if (isCram) nextCram = adr;
      else nextDram = adr;
    end
    for (int k = 0; k < groups; k++) begin
      for (int j = 0; j < n; j++) begin
        g[j] = tWord16'($urandom);
        words.push_back(g[j]);
      end
      if (isCram) begin
        expCramAddr.push_back(nextCram);
        expCramData.push_back({g[5][5:0], g[0], g[1], g[2], g[3], g[4]});
        nextCram++;
      end else begin
        expDramAddr.push_back(nextDram);
        expDram.push_back(g[0]);
        expDram.push_back(g[1]);
        expDram.push_back(g[2]);
        nextDram += 2;
      end
    end
    sum = '0;
    foreach (words[i]) sum += words[i];
    words.push_back(-sum + tWord16'(corrupt));
    sendLine(isCram ? REC_CRAM : REC_DRAM, words);
  endtask

  task automatic sendEnd(input tChar t);
    sendLine(t, '{16'h0, 16'h0, 16'h0});
  endtask

  // Reset everything and preset the MBOX model
  task automatic applyReset(input int tries);
    rstN = 1'b0;
    charValid = 1'b0;
    charData = '0;
    holdTries = tries;
    clocksSeen = 0;
    aChangeComingN = (tries == 0);
    nextCram = 0;
    nextDram = 0;
    expCramAddr.delete();
    expCramData.delete();
    expDramAddr.delete();
    expDram.delete();
    expFunc.delete();
    expWrite.delete();
    expData.delete();
    repeat (16) @(negedge clk);
    rstN = 1'b1;
    checkTrue(crobar && !cramWe && !dramWe && !loadDone && !seqDone,
              "outputs not at their reset values");
    checkTrue(!diagStrobe && !ebusDriving && !checksumError && !formatError && !syncError,
              "flags not clear after reset");
  endtask

  // Step table expanded with the expected number of sync step clocks
  task automatic expectSequence(input int clocks);
    for (int i = 0; i < RESET_STEP_COUNT; i++) begin
      if (RESET_STEPS[i].kind == stepSync) begin
        for (int c = 0; c < clocks; c++) begin
          expFunc.push_back(diagStepClock);
          expWrite.push_back(1'b0);
          expData.push_back('0);
        end
      end else begin
        expFunc.push_back(RESET_STEPS[i].func);
        expWrite.push_back(RESET_STEPS[i].kind == stepWrite);
        expData.push_back(RESET_STEPS[i].kind == stepWrite ? RESET_STEPS[i].data : '0);
      end
    end
  endtask

  // Short clean load, then the whole reset sequence
  task automatic runSequence(input int tries, input int clocks, input bit expSyncErr);
    applyReset(tries);
    expectSequence(clocks);
    sendDataLine(1'b0, 16, 1, 1'b0);
    sendEnd(REC_DRAM);
    while (!seqDone) @(negedge clk);
    checkTrue(expFunc.size() == 0, "reset sequence ended early");
    checkValue("syncError", expSyncErr, syncError);
  endtask

  initial begin
    void'($urandom(32'h9132_14e1));
    prevStrobe = 1'b0;

    // Clean load with continuation, skipped lines and the full sequence
    applyReset(0);
    expectSequence(0);
    sendDataLine(1'b1, 100, 3, 1'b0);
    sendDataLine(1'b1, 0, 2, 1'b0);
    sendLine(REC_ZERO, '{16'h0005, 16'h0010});
    sendLine(REC_COMMENT, '{16'h1234, 16'h0abc});
    sendDataLine(1'b0, 40, 2, 1'b0);
    sendDataLine(1'b0, 0, 3, 1'b0);
    sendEnd(REC_CRAM);
    // Checksum word reaches the parser two clocks after the line end
    repeat (3) @(negedge clk);
    checkValue("loadDone", 1'b0, loadDone);
    sendEnd(REC_DRAM);
    while (!loadDone) @(negedge clk);
    checkTrue(expCramAddr.size() == 0 && expDramAddr.size() == 0, "RAM writes missing");
    checkTrue(!checksumError && !formatError, "error flag set on a clean load");
    while (!seqDone) @(negedge clk);
    checkTrue(expFunc.size() == 0, "reset sequence ended early");
    checkValue("syncError", 1'b0, syncError);

    // Corrupted checksum keeps crobar high
    applyReset(0);
    sendDataLine(1'b1, 7, 1, 1'b1);
    sendEnd(REC_DRAM);
    while (!loadDone) @(negedge clk);
    repeat (CROBAR_DELAY + 40) @(negedge clk);
    checkValue("checksumError", 1'b1, checksumError);
    checkValue("crobar", 1'b1, crobar);

    // MBOX released after two tries, then never released
    runSequence(2, 2, 1'b0);
    runSequence(1000, SYNC_TRIES, 1'b1);

    if (i_dut.i_asserts.errCount == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1);
    end
  end

endmodule

//--- all.f
hw/feLoadPkg.sv
hw/asciiWordDecoder.sv
hw/loadRecordParser.sv
hw/diagCycleGen.sv
hw/klResetSequencer.sv
hw/frontEnd.sv
verif/frontEndAsserts.sv
verif/frontEndTb.sv
